// File: compile.f
rtl/hk_pkg.sv
rtl/hk_dna_shifter.sv
rtl/hk_clock_mon.sv
rtl/hk_regs.sv
rtl/hk_top.sv
verification/hk_checker.sv
verification/hk_tb.sv

// File: rtl/hk_clock_mon.sv
`timescale 1ns/1ps

// Measures external clocks against the bus clock
// Each clock drives a Gray-coded edge counter in its own domain
// The bus side samples every counter once per window
module hk_clock_mon (
    input  logic                              wb_clk_i,
    input  logic                              wb_rst_i,
    // Monitored clocks in the order sys, gtp, rx, clk200
    input  logic [hk_pkg::NUM_MON_CLOCKS-1:0] mon_clk_i,
    // Access strobe for the monitor region
    input  logic                              sel_i,
    // Word index inside the region
    input  logic [1:0]                        adr_i,
    output logic [hk_pkg::DAT_W-1:0]          dat_o,
    output logic [hk_pkg::NUM_MON_CLOCKS-1:0] running_o
);

    // Gray code back to binary
    function automatic logic [hk_pkg::MON_CNT_W-1:0] gray2bin(
        input logic [hk_pkg::MON_CNT_W-1:0] g
    );
        logic [hk_pkg::MON_CNT_W-1:0] b;
        b[hk_pkg::MON_CNT_W-1] = g[hk_pkg::MON_CNT_W-1];
        for (int i = hk_pkg::MON_CNT_W - 2; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // Gray counts leaving each monitored domain
    logic [hk_pkg::MON_CNT_W-1:0] gray_src [hk_pkg::NUM_MON_CLOCKS];

    // Bus-domain synchronizer stages
    logic [hk_pkg::MON_CNT_W-1:0] gray_meta [hk_pkg::NUM_MON_CLOCKS];
    logic [hk_pkg::MON_CNT_W-1:0] gray_sync [hk_pkg::NUM_MON_CLOCKS];

    // Previous sample and the per-window difference
    logic [hk_pkg::MON_CNT_W-1:0] prev_q  [hk_pkg::NUM_MON_CLOCKS];
    logic [hk_pkg::MON_CNT_W-1:0] count_q [hk_pkg::NUM_MON_CLOCKS];
    logic [hk_pkg::NUM_MON_CLOCKS-1:0] running_q;

    // Window timer
    logic [hk_pkg::MON_WINDOW_LOG2-1:0] window_cnt;
    logic                               window_end;

    // Source-domain counters
    for (genvar g = 0; g < hk_pkg::NUM_MON_CLOCKS; g++) begin : g_src
        // Free-running binary count and its Gray copy
        logic [hk_pkg::MON_CNT_W-1:0] bin_q  = '0;
        logic [hk_pkg::MON_CNT_W-1:0] gray_q = '0;
        logic [hk_pkg::MON_CNT_W-1:0] bin_next;

        assign bin_next = bin_q + 1'b1;

        always_ff @(posedge mon_clk_i[g]) begin
            bin_q  <= bin_next;
            // Registered Gray value moves one bit per edge
            gray_q <= bin_next ^ (bin_next >> 1);
        end

        assign gray_src[g] = gray_q;
    end

    // Two-flop synchronizer per clock
    // Gray coding keeps each sample within one count of the source
    always_ff @(posedge wb_clk_i) begin
        for (int c = 0; c < hk_pkg::NUM_MON_CLOCKS; c++) begin
            gray_meta[c] <= gray_src[c];
            gray_sync[c] <= gray_meta[c];
        end
    end

    assign window_end = &window_cnt;

    // Window timer and per-window results
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            window_cnt <= '0;
            running_q  <= '0;
            for (int c = 0; c < hk_pkg::NUM_MON_CLOCKS; c++) begin
                prev_q[c]  <= '0;
                count_q[c] <= '0;
            end
        end else begin
            window_cnt <= window_cnt + 1'b1;
            if (window_end) begin
                for (int c = 0; c < hk_pkg::NUM_MON_CLOCKS; c++) begin
                    prev_q[c]  <= gray2bin(gray_sync[c]);
                    // Difference wraps correctly across counter rollover
                    count_q[c] <= gray2bin(gray_sync[c]) - prev_q[c];
                    running_q[c] <= (gray2bin(gray_sync[c]) - prev_q[c])
                                    >= hk_pkg::MON_CNT_W'(hk_pkg::MON_RUN_MIN);
                end
            end
        end
    end

    // Read path with the running flag in bit 31 and the count in the low bits
    always_comb begin
        dat_o = '0;
        if (sel_i) begin
            dat_o = {running_q[adr_i],
                     {(hk_pkg::DAT_W - 1 - hk_pkg::MON_CNT_W){1'b0}},
                     count_q[adr_i]};
        end
    end

    assign running_o = running_q;

endmodule

// File: rtl/hk_dna_shifter.sv
`timescale 1ns/1ps

// Stand-in for the device identity port
// Loaded in parallel, then read out one bit per bus access
module hk_dna_shifter (
    input  logic wb_clk_i,
    input  logic wb_rst_i,
    // Reload the full identity
    input  logic load_i,
    // Advance to the next bit
    input  logic shift_i,
    // Current MSB of the register
    output logic bit_o
);

    // Identity shift register
    logic [hk_pkg::DNA_W-1:0] dna_sr;

    // Reset and load both restore the identity
    // Load wins over a shift in the same cycle
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            dna_sr <= hk_pkg::DNA_VALUE;
        end else if (load_i) begin
            dna_sr <= hk_pkg::DNA_VALUE;
        end else if (shift_i) begin
            // Move toward the MSB, zero fills from below
            dna_sr <= {dna_sr[hk_pkg::DNA_W-2:0], 1'b0};
        end
    end

    // After DNA_W shifts only zeros remain
    assign bit_o = dna_sr[hk_pkg::DNA_W-1];

endmodule

// File: rtl/hk_pkg.sv
package hk_pkg;

    // Bus widths
    localparam int ADR_W = 12;
    localparam int DAT_W = 32;

    // Register byte addresses
    localparam logic [ADR_W-1:0] ADR_DEVICE      = 12'h000;
    localparam logic [ADR_W-1:0] ADR_VERSION     = 12'h004;
    localparam logic [ADR_W-1:0] ADR_DNA         = 12'h008;
    localparam logic [ADR_W-1:0] ADR_CTRLSTAT    = 12'h00C;
    localparam logic [ADR_W-1:0] ADR_SYNC        = 12'h010;
    localparam logic [ADR_W-1:0] ADR_CLKOFS      = 12'h014;
    // Clock monitor window, one word per clock from here on
    localparam logic [ADR_W-1:0] ADR_CLKMON_BASE = 12'h040;

    // Identification words
    localparam logic [DAT_W-1:0] DEVICE_ID  = "HKBC";
    // Packed as day, month, major, minor, revision fields
    localparam logic [DAT_W-1:0] FW_VERSION = 32'h0811_2103;

    // Device identity, shifted out MSB first
    localparam int           DNA_W     = 57;
    localparam logic [DNA_W-1:0] DNA_VALUE = 57'h15A3C96E10F2DB7;

    // Clock monitor, order is sys, gtp, rx, clk200
    localparam int NUM_MON_CLOCKS  = 4;
    localparam int MON_WINDOW_LOG2 = 10;
    localparam int MON_CNT_W       = 24;
    localparam int MON_RUN_MIN     = 16;

    // Control/status word, written and read with different layouts
    typedef union packed {
        struct packed {
            logic [27:0] ignored_hi;
            logic        enable_3v3;
            logic        enable_crate;
            logic [1:0]  ignored_lo;
        } wr;
        struct packed {
            logic [21:0] zero_hi;
            logic [1:0]  crate_conf;
            logic [3:0]  zero_mid;
            logic        enable_3v3;
            logic        enable_crate;
            logic        rx_ok;
            logic        sys_ok;
        } rd;
    } ctrlstat_u;

endpackage

// File: rtl/hk_regs.sv
`timescale 1ns/1ps

// Wishbone slave for the housekeeping registers
// Owns the low register words and every unmapped address
module hk_regs (
    input  logic                              wb_clk_i,
    input  logic                              wb_rst_i,
    // Wishbone slave
    input  logic                              wb_cyc_i,
    input  logic                              wb_stb_i,
    input  logic                              wb_we_i,
    input  logic [hk_pkg::ADR_W-1:0]          wb_adr_i,
    input  logic [hk_pkg::DAT_W-1:0]          wb_dat_i,
    input  logic [3:0]                        wb_sel_i,
    output logic [hk_pkg::DAT_W-1:0]          wb_dat_o,
    output logic                              wb_ack_o,
    // Identity shifter
    input  logic                              dna_bit_i,
    output logic                              dna_load_o,
    output logic                              dna_shift_o,
    // Clock monitor
    output logic                              mon_sel_o,
    input  logic [hk_pkg::DAT_W-1:0]          mon_dat_i,
    input  logic [hk_pkg::NUM_MON_CLOCKS-1:0] mon_running_i,
    // Board straps
    input  logic [1:0]                        crate_conf_i,
    // Timing logic controls
    output logic [7:0]                        sync_offset_o,
    output logic                              en_ext_sync_o,
    output logic [7:0]                        clk_offset_o,
    // Power enables
    output logic                              enable_crate_o,
    output logic                              enable_3v3_o,
    // Clock health
    output logic                              sys_clk_ok_o,
    output logic                              rx_clk_ok_o
);

    // Word-aligned address for decoding
    logic [hk_pkg::ADR_W-1:0] word_adr;
    logic                     in_mon;
    logic                     req;
    logic                     wr_req;
    logic                     ack_q;

    // Word selects
    logic sel_dna;
    logic sel_ctrlstat;
    logic sel_sync;
    logic sel_clkofs;

    // Registers
    logic [8:0] sync_plus_en;
    logic [7:0] clk_offset_q;
    logic       enable_crate_q;
    logic       enable_3v3_q;
    logic [1:0] crate_conf_q;

    // Two views of the control/status word
    hk_pkg::ctrlstat_u ctrl_wr;
    hk_pkg::ctrlstat_u status_word;

    logic [hk_pkg::DAT_W-1:0] rd_data;

    assign word_adr = {wb_adr_i[hk_pkg::ADR_W-1:2], 2'b00};
    // Monitor region is 0x040 to 0x07F
    assign in_mon = ({wb_adr_i[hk_pkg::ADR_W-1:6], 6'd0} == hk_pkg::ADR_CLKMON_BASE);

    assign sel_dna      = (word_adr == hk_pkg::ADR_DNA);
    assign sel_ctrlstat = (word_adr == hk_pkg::ADR_CTRLSTAT);
    assign sel_sync     = (word_adr == hk_pkg::ADR_SYNC);
    assign sel_clkofs   = (word_adr == hk_pkg::ADR_CLKOFS);

    // New request, not yet acknowledged
    assign req    = wb_cyc_i && wb_stb_i && !ack_q;
    // Writes land on the edge that raises ack
    assign wr_req = req && wb_we_i;

    // One-cycle ack for every address, never on two cycles in a row
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    assign ctrl_wr = wb_dat_i;

    // Control registers
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            sync_plus_en   <= '0;
            clk_offset_q   <= '0;
            enable_crate_q <= 1'b1;
            enable_3v3_q   <= 1'b1;
        end else begin
            if (wr_req && sel_sync) begin
                sync_plus_en <= wb_dat_i[8:0];
            end
            if (wr_req && sel_clkofs) begin
                clk_offset_q <= wb_dat_i[7:0];
            end
            // Enables live in byte 0
            if (wr_req && sel_ctrlstat && wb_sel_i[0]) begin
                enable_crate_q <= ctrl_wr.wr.enable_crate;
                enable_3v3_q   <= ctrl_wr.wr.enable_3v3;
            end
        end
    end

    // Strap sampled every cycle
    always_ff @(posedge wb_clk_i) begin
        crate_conf_q <= crate_conf_i;
    end

    // Identity control, load on a qualified write
    assign dna_load_o  = wr_req && sel_dna && wb_sel_i[3] && wb_dat_i[31];
    // Shift after the read data has been presented
    assign dna_shift_o = ack_q && wb_cyc_i && wb_stb_i && !wb_we_i && sel_dna;

    // Only the first four words of the region map to clocks
    assign mon_sel_o = wb_cyc_i && wb_stb_i && in_mon && (wb_adr_i[5:4] == 2'b00);

    // Status read layout
    always_comb begin
        status_word                 = '0;
        status_word.rd.sys_ok       = mon_running_i[0];
        status_word.rd.rx_ok        = mon_running_i[2];
        status_word.rd.enable_crate = enable_crate_q;
        status_word.rd.enable_3v3   = enable_3v3_q;
        status_word.rd.crate_conf   = crate_conf_q;
    end

    // Read mux, reserved and unmapped words return zero
    always_comb begin
        rd_data = '0;
        if (in_mon) begin
            rd_data = mon_dat_i;
        end else begin
            case (word_adr)
                hk_pkg::ADR_DEVICE:   rd_data = hk_pkg::DEVICE_ID;
                hk_pkg::ADR_VERSION:  rd_data = hk_pkg::FW_VERSION;
                hk_pkg::ADR_DNA:      rd_data = {31'd0, dna_bit_i};
                hk_pkg::ADR_CTRLSTAT: rd_data = status_word;
                hk_pkg::ADR_SYNC:     rd_data = {23'd0, sync_plus_en};
                hk_pkg::ADR_CLKOFS:   rd_data = {24'd0, clk_offset_q};
                default:              rd_data = '0;
            endcase
        end
    end

    assign wb_dat_o = rd_data;
    assign wb_ack_o = ack_q;

    assign sync_offset_o  = sync_plus_en[7:0];
    assign en_ext_sync_o  = sync_plus_en[8];
    assign clk_offset_o   = clk_offset_q;
    assign enable_crate_o = enable_crate_q;
    assign enable_3v3_o   = enable_3v3_q;
    // sys is clock 0, rx is clock 2
    assign sys_clk_ok_o   = mon_running_i[0];
    assign rx_clk_ok_o    = mon_running_i[2];

endmodule

// File: rtl/hk_top.sv
`timescale 1ns/1ps

// Housekeeping block for the board controller
module hk_top (
    input  logic                     wb_clk_i,
    input  logic                     wb_rst_i,
    // Wishbone slave
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  logic [hk_pkg::ADR_W-1:0] wb_adr_i,
    input  logic [hk_pkg::DAT_W-1:0] wb_dat_i,
    input  logic [3:0]               wb_sel_i,
    output logic [hk_pkg::DAT_W-1:0] wb_dat_o,
    output logic                     wb_ack_o,
    // Board straps
    input  logic [1:0]               crate_conf_i,
    // Monitored clocks
    input  logic                     sys_clk_i,
    input  logic                     gtp_clk_i,
    input  logic                     rx_clk_i,
    input  logic                     clk200_i,
    // Control outputs
    output logic [7:0]               sync_offset_o,
    output logic                     en_ext_sync_o,
    output logic [7:0]               clk_offset_o,
    output logic                     enable_crate_o,
    output logic                     enable_3v3_o,
    output logic                     sys_clk_ok_o,
    output logic                     rx_clk_ok_o
);

    // Identity shifter links
    logic dna_bit;
    logic dna_load;
    logic dna_shift;

    // Clock monitor links
    logic                              mon_sel;
    logic [hk_pkg::DAT_W-1:0]          mon_dat;
    logic [hk_pkg::NUM_MON_CLOCKS-1:0] mon_running;

    hk_regs hk_regs_inst (
        .wb_clk_i       (wb_clk_i),
        .wb_rst_i       (wb_rst_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_sel_i       (wb_sel_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .dna_bit_i      (dna_bit),
        .dna_load_o     (dna_load),
        .dna_shift_o    (dna_shift),
        .mon_sel_o      (mon_sel),
        .mon_dat_i      (mon_dat),
        .mon_running_i  (mon_running),
        .crate_conf_i   (crate_conf_i),
        .sync_offset_o  (sync_offset_o),
        .en_ext_sync_o  (en_ext_sync_o),
        .clk_offset_o   (clk_offset_o),
        .enable_crate_o (enable_crate_o),
        .enable_3v3_o   (enable_3v3_o),
        .sys_clk_ok_o   (sys_clk_ok_o),
        .rx_clk_ok_o    (rx_clk_ok_o)
    );

    hk_dna_shifter hk_dna_shifter_inst (
        .wb_clk_i (wb_clk_i),
        .wb_rst_i (wb_rst_i),
        .load_i   (dna_load),
        .shift_i  (dna_shift),
        .bit_o    (dna_bit)
    );

    // Clock order from LSB: sys, gtp, rx, clk200
    hk_clock_mon hk_clock_mon_inst (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .mon_clk_i ({clk200_i, rx_clk_i, gtp_clk_i, sys_clk_i}),
        .sel_i     (mon_sel),
        .adr_i     (wb_adr_i[3:2]),
        .dat_o     (mon_dat),
        .running_o (mon_running)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the housekeeping testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module hk_tb \
    -f compile.f -o hk_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/hk_sim > sim.log 2>&1 ; cat sim.log
grep -qF '*** TEST PASSED ***' sim.log && echo "Simulation passed" || {
    echo "Simulation failed"
    exit 1
}

// File: verification/hk_checker.sv
`timescale 1ns/1ps

// Handshake and register update rules for hk_regs
module hk_checker (
    input logic       wb_clk_i,
    input logic       wb_rst_i,
    input logic       wb_cyc_i,
    input logic       wb_stb_i,
    input logic       wb_we_i,
    input logic       wb_ack_o,
    input logic [7:0] sync_offset_o,
    input logic       en_ext_sync_o,
    input logic [7:0] clk_offset_o
);

    // Failed assertions so far
    int assert_fails = 0;

    // Ack answers a request seen on the previous edge
    ack_follows_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
        else begin
            assert_fails++;
            $error("Ack raised without a request");
        end

    ack_single_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wb_ack_o |=> !wb_ack_o)
        else begin
            assert_fails++;
            $error("Ack held for two cycles");
        end

    // Timing outputs move only on the edge that acks a write
    offsets_on_write: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        !$stable({sync_offset_o, en_ext_sync_o, clk_offset_o})
        |-> wb_ack_o && $past(wb_cyc_i && wb_stb_i && wb_we_i))
        else begin
            assert_fails++;
            $error("Offset output changed outside an acked write");
        end

endmodule

bind hk_regs hk_checker hk_checker_inst (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_ack_o      (wb_ack_o),
    .sync_offset_o (sync_offset_o),
    .en_ext_sync_o (en_ext_sync_o),
    .clk_offset_o  (clk_offset_o)
);

// File: verification/hk_tb.sv
`timescale 1ns/1ps

// Testbench for hk_top, replays the bus trace and checks every result
module hk_tb;

    // Ack is expected one bus cycle after the request
    localparam int ACK_LATENCY = 1;
    localparam int ACK_TIMEOUT = 16;
    // Allow several measurement windows for the running flags
    localparam int MON_TIMEOUT = 4 << hk_pkg::MON_WINDOW_LOG2;

    // Clocks
    logic wb_clk  = 1'b0;
    logic sys_clk = 1'b0;
    logic gtp_clk = 1'b0;
    logic rx_clk  = 1'b0;
    logic clk200  = 1'b0;

    // DUT inputs
    logic                     wb_rst;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [hk_pkg::ADR_W-1:0] wb_adr;
    logic [hk_pkg::DAT_W-1:0] wb_dat_w;
    logic [3:0]               wb_sel;
    logic [1:0]               crate_conf;

    // DUT outputs
    logic [hk_pkg::DAT_W-1:0] wb_dat_r;
    logic                     wb_ack;
    logic [7:0]               sync_offset;
    logic                     en_ext_sync;
    logic [7:0]               clk_offset;
    logic                     enable_crate;
    logic                     enable_3v3;
    logic                     sys_clk_ok;
    logic                     rx_clk_ok;

    // Output ports packed for the O trace operation
    logic [20:0] out_vec;

    always #2 wb_clk = ~wb_clk;
    always #4 sys_clk = ~sys_clk;
    always #4 rx_clk = ~rx_clk;
    always #2.5 clk200 = ~clk200;
    // gtp_clk is never toggled

    assign out_vec = {sys_clk_ok, rx_clk_ok, enable_crate, enable_3v3,
                      en_ext_sync, sync_offset, clk_offset};

    hk_top hk_top_inst (
        .wb_clk_i       (wb_clk),
        .wb_rst_i       (wb_rst),
        .wb_cyc_i       (wb_cyc),
        .wb_stb_i       (wb_stb),
        .wb_we_i        (wb_we),
        .wb_adr_i       (wb_adr),
        .wb_dat_i       (wb_dat_w),
        .wb_sel_i       (wb_sel),
        .wb_dat_o       (wb_dat_r),
        .wb_ack_o       (wb_ack),
        .crate_conf_i   (crate_conf),
        .sys_clk_i      (sys_clk),
        .gtp_clk_i      (gtp_clk),
        .rx_clk_i       (rx_clk),
        .clk200_i       (clk200),
        .sync_offset_o  (sync_offset),
        .en_ext_sync_o  (en_ext_sync),
        .clk_offset_o   (clk_offset),
        .enable_crate_o (enable_crate),
        .enable_3v3_o   (enable_3v3),
        .sys_clk_ok_o   (sys_clk_ok),
        .rx_clk_ok_o    (rx_clk_ok)
    );

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    // Accepts a difference of up to tol between the two values
    task automatic check_value(input string name, input logic [31:0] expv,
                               input logic [31:0] act, input logic [31:0] tol);
        logic [31:0] diff;
        diff = (act > expv) ? act - expv : expv - act;
        if ($isunknown(act) || diff > tol) begin
            $display("ERROR: %s expected %h actual %h", name, expv, act);
            abort_run();
        end
    endtask

    // One Wishbone classic cycle, data sampled on the falling edge while ack is high
    task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                              input logic [31:0] sel, input string name,
                              output logic [31:0] rd);
        int cycles;
        cycles = 0;
        @(posedge wb_clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr[hk_pkg::ADR_W-1:0];
        wb_dat_w <= dat;
        wb_sel   <= sel[3:0];
        @(negedge wb_clk);
        while (!wb_ack) begin
            if (cycles >= ACK_TIMEOUT) begin
                $display("The DUT never acknowledged the bus cycle of %s", name);
                abort_run();
            end
            @(negedge wb_clk);
            cycles++;
        end
        rd = wb_dat_r;
        check_value({name, "_ack_latency"}, ACK_LATENCY, cycles, 0);
        // Release the bus so stb is low for at least one cycle
        @(posedge wb_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    // Waits for both clock flags, then one more window so the counts are exact
    task automatic wait_monitor(input string name);
        int cycles;
        cycles = 0;
        while (!(sys_clk_ok && rx_clk_ok)) begin
            if (cycles >= MON_TIMEOUT) begin
                $display("The clock monitor flags never rose during %s", name);
                abort_run();
            end
            @(negedge wb_clk);
            cycles++;
        end
        cycles = 0;
        while (cycles < (1 << hk_pkg::MON_WINDOW_LOG2) + 8) begin
            @(negedge wb_clk);
            cycles++;
        end
    endtask

    task automatic run_trace_op(input logic [7:0] op, input logic [31:0] adr,
                                input logic [31:0] dat, input logic [31:0] sel,
                                input logic [31:0] expv, input logic [31:0] tol,
                                input string name);
        logic [31:0] rd;
        logic [31:0] acc;
        case (op)
            "W": bus_access(1'b1, adr, dat, sel, name, rd);
            "R": begin
                bus_access(1'b0, adr, 32'd0, sel, name, rd);
                check_value(name, expv, rd, tol);
            end
            "D": begin
                // Repeated identity reads, bits packed MSB first
                acc = '0;
                for (int i = 0; i < int'(dat); i++) begin
                    bus_access(1'b0, adr, 32'd0, sel, name, rd);
                    acc = (acc << 1) | rd;
                end
                check_value(name, expv, acc, tol);
            end
            "O": begin
                @(negedge wb_clk);
                check_value(name, expv, {11'd0, out_vec}, tol);
            end
            "M": wait_monitor(name);
            default: begin
                $display("Unknown operation in the trace at %s", name);
                abort_run();
            end
        endcase
    endtask

    initial begin : main
        string       line;
        string       name;
        int          fd;
        int          lineno;
        int          n;
        logic [7:0]  op;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [31:0] sel;
        logic [31:0] expv;
        logic [31:0] tol;
        wb_rst     = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        wb_sel     = '0;
        crate_conf = 2'b10;
        fd = $fopen("verification/hk_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file verification/hk_trace.txt");
            abort_run();
        end
        repeat (5) @(posedge wb_clk);
        wb_rst <= 1'b0;
        lineno = 0;
        while ($fgets(line, fd) != 0) begin
            lineno++;
            // Skip comments and blank lines
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h %h %h", op, adr, dat, sel, expv, tol);
                if (n != 6) begin
                    $display("Trace line %0d could not be parsed", lineno);
                    abort_run();
                end
                name = $sformatf("line%0d_%c_%03h", lineno, op, adr[11:0]);
                run_trace_op(op, adr, dat, sel, expv, tol, name);
            end
        end
        $fclose(fd);
        if (hk_top_inst.hk_regs_inst.hk_checker_inst.assert_fails == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("The bus checker saw %0d assertion failures",
                     hk_top_inst.hk_regs_inst.hk_checker_inst.assert_fails);
            abort_run();
        end
    end

endmodule

// File: verification/hk_trace.txt
# op addr data sel expected tolerance, all hex; W write, R read, D read addr <data> times
# O checks {sys_ok,rx_ok,en_crate,en_3v3,ext_sync,sync[7:0],clkofs[7:0]}, M waits for monitor
R 000 00000000 F 484B4243 0
R 004 00000000 F 08112103 0
R 00C 00000000 F 0000020C 0
O 000 00000000 0 00060000 0
W 010 000001A5 F 00000000 0
R 010 00000000 F 000001A5 0
W 014 0000003C F 00000000 0
R 014 00000000 F 0000003C 0
O 000 00000000 0 0007A53C 0
W 00C 00000000 E 00000000 0
R 00C 00000000 F 0000020C 0
W 00C 00000000 1 00000000 0
R 00C 00000000 F 00000200 0
O 000 00000000 0 0001A53C 0
W 00C 0000000C 1 00000000 0
R 00C 00000000 F 0000020C 0
R 008 00000000 F 00000001 0
R 008 00000000 F 00000000 0
W 008 80000000 F 00000000 0
D 008 00000019 F 015A3C96 0
D 008 00000020 F E10F2DB7 0
R 008 00000000 F 00000000 0
W 008 80000000 7 00000000 0
R 008 00000000 F 00000000 0
W 008 80000000 8 00000000 0
R 008 00000000 F 00000001 0
W 020 FFFFFFFF F 00000000 0
R 020 00000000 F 00000000 0
W 800 FFFFFFFF F 00000000 0
R 800 00000000 F 00000000 0
O 000 00000000 0 0007A53C 0
M 000 00000000 0 00000000 0
O 000 00000000 0 001FA53C 0
R 040 00000000 F 80000200 2
R 044 00000000 F 00000000 0
R 048 00000000 F 80000200 2
R 04C 00000000 F 80000333 2
R 00C 00000000 F 0000020F 0
